//--- bench/i2c_slv_tb.sv
`timescale 1ns/1ps

module i2c_slv_tb import i2c_slv_pkg::*; ();

    localparam int         HALF     = 20;
    localparam int         QTR      = 5;
    localparam int         TMO      = 200;
    localparam logic [6:0] TGT_ADDR = 7'h3A;

    logic      i_sysclk;
    logic      i_rst_n;
    logic      scl_m;
    logic      sda_pd;
    logic      sda_oe;
    logic      oe_watch;
    logic      oe_seen;
    logic [3:0] sh_ptr;
    i2c_byte_t shadow [16];
    i2c_byte_t xfer_q [$];
    i2c_ack_e  ack_got_q [$];
    i2c_ack_e  ack_exp_q [$];
    i2c_byte_t byte_got_q [$];
    i2c_byte_t byte_exp_q [$];
    int        seed;
    int        err_cnt;
    int        test_err;
    int        tests_ok;
    int        tests_bad;

    // the open-drain SDA is low when the master or the target pulls it down.
    wire sda_bus = ~(sda_pd | sda_oe);

    i2c_slv_top DUT (
        .i_sysclk (i_sysclk),
        .i_rst_n  (i_rst_n),
        .i_scl    (scl_m),
        .i_sda    (sda_bus),
        .o_sda_oe (sda_oe)
    );

    initial begin
        i_sysclk = 1'b0;
        forever #4 i_sysclk = ~i_sysclk;
    end

    // flags any pull-down by the DUT while a watch window is open.
    always @(posedge i_sysclk) begin
        if (!oe_watch) begin
            oe_seen <= 1'b0;
        end else if (sda_oe) begin
            oe_seen <= 1'b1;
        end
    end

    // ##################################################################
    // reference model and comparison
    // ##################################################################

    function automatic i2c_byte_t expected_read(input int k);
        return shadow[4'((sh_ptr + k) % 16)];
    endfunction

    function automatic i2c_byte_t rand_byte();
        return 8'($random(seed));
    endfunction

    task automatic check_ack(input i2c_ack_e got, input i2c_ack_e exp);
        if (got != exp) begin
            $display("** Error at %0t: acknowledge is %s, expected %s",
                     $time, got.name(), exp.name());
            err_cnt++;
        end
    endtask

    task automatic check_byte(input i2c_byte_t got, input i2c_byte_t exp);
        if (got != exp) begin
            $display("** Error at %0t: read byte is %02h, expected %02h", $time, got, exp);
            err_cnt++;
        end
    endtask

    initial begin
        forever begin
            @(posedge i_sysclk);
            while (ack_got_q.size() > 0) begin
                check_ack(ack_got_q.pop_front(), ack_exp_q.pop_front());
            end
            while (byte_got_q.size() > 0) begin
                check_byte(byte_got_q.pop_front(), byte_exp_q.pop_front());
            end
        end
    end

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while ((ack_got_q.size() + byte_got_q.size()) > 0 && cnt < TMO) begin
            @(posedge i_sysclk);
            cnt++;
        end
        if ((ack_got_q.size() + byte_got_q.size()) > 0) begin
            $display("timeout: results were not compared within %0d cycles", TMO);
            err_cnt++;
        end
    endtask

    // ##################################################################
    // bus master
    // ##################################################################

    task automatic pause(input int n);
        repeat (n) @(posedge i_sysclk);
    endtask

    // each bit starts right after SCL falls and ends with the next fall.
    task automatic drive_bit(input logic b);
        pause(QTR);
        sda_pd <= ~b;
        pause(HALF - QTR);
        scl_m <= 1'b1;
        pause(HALF);
        scl_m <= 1'b0;
    endtask

    task automatic sample_bit(output logic b);
        pause(QTR);
        sda_pd <= 1'b0;
        pause(HALF - QTR);
        scl_m <= 1'b1;
        pause(HALF / 2);
        b = sda_bus;
        pause(HALF / 2);
        scl_m <= 1'b0;
    endtask

    task automatic start_cond();
        sda_pd <= 1'b1;
        pause(HALF);
        scl_m <= 1'b0;
    endtask

    task automatic restart_cond();
        pause(QTR);
        sda_pd <= 1'b0;
        pause(HALF - QTR);
        scl_m <= 1'b1;
        pause(HALF);
        start_cond();
    endtask

    task automatic stop_cond();
        pause(QTR);
        sda_pd <= 1'b1;
        pause(HALF - QTR);
        scl_m <= 1'b1;
        pause(HALF);
        sda_pd <= 1'b0;
        pause(HALF);
    endtask

    task automatic write_byte(input i2c_byte_t d, output i2c_ack_e ack);
        logic b;
        repeat (8) begin
            drive_bit(d[7]);
            d = {d[6:0], 1'b0};
        end
        sample_bit(b);
        ack = i2c_ack_e'(b);
    endtask

    task automatic read_byte(input i2c_ack_e ack, output i2c_byte_t d);
        logic b;
        d = '0;
        repeat (8) begin
            sample_bit(b);
            d = {d[6:0], b};
        end
        drive_bit(ack);
    endtask

    task automatic partial_bits(input i2c_byte_t d);
        repeat (3) begin
            drive_bit(d[7]);
            d = {d[6:0], 1'b0};
        end
    endtask

    task automatic address_phase(input logic [6:0] addr, input logic rw, input i2c_ack_e exp);
        i2c_ack_e ack;
        write_byte({addr, rw}, ack);
        ack_got_q.push_back(ack);
        ack_exp_q.push_back(exp);
    endtask

    task automatic data_byte(input i2c_byte_t d, input i2c_ack_e exp);
        i2c_ack_e ack;
        write_byte(d, ack);
        ack_got_q.push_back(ack);
        ack_exp_q.push_back(exp);
    endtask

    task automatic collect_byte(input i2c_ack_e ack, input i2c_byte_t exp);
        i2c_byte_t d;
        read_byte(ack, d);
        byte_got_q.push_back(d);
        byte_exp_q.push_back(exp);
    endtask

    // the first data byte of a write transfer sets the register pointer.
    task automatic pointer_phase(input logic [3:0] ptr);
        start_cond();
        address_phase(TGT_ADDR, 1'b0, ACK);
        data_byte({4'h0, ptr}, ACK);
        sh_ptr = ptr;
    endtask

    task automatic write_regs(input logic [3:0] ptr);
        i2c_byte_t d;
        pointer_phase(ptr);
        while (xfer_q.size() > 0) begin
            d = xfer_q.pop_front();
            data_byte(d, ACK);
            shadow[sh_ptr] = d;
            sh_ptr = sh_ptr + 4'd1;
        end
        stop_cond();
    endtask

    // the pointer only moves on bytes that the master acknowledges.
    task automatic read_regs(input logic [3:0] ptr, input int n);
        pointer_phase(ptr);
        restart_cond();
        address_phase(TGT_ADDR, 1'b1, ACK);
        for (int k = 0; k < n; k++) begin
            collect_byte((k == n - 1) ? NACK : ACK, expected_read(k));
        end
        sh_ptr = 4'(sh_ptr + n - 1);
        // after the final NACK the target leaves SDA to the master.
        oe_watch <= 1'b1;
        stop_cond();
        oe_watch <= 1'b0;
        if (oe_seen) begin
            $display("DUT pulled SDA low after the NACK of the last read byte");
            err_cnt++;
        end
    endtask

    // ##################################################################
    // tests
    // ##################################################################

    task automatic addressing_test();
        start_cond();
        address_phase(TGT_ADDR, 1'b0, ACK);
        stop_cond();
        start_cond();
        address_phase(TGT_ADDR, 1'b1, ACK);
        collect_byte(NACK, expected_read(0));
        stop_cond();
        oe_watch <= 1'b1;
        start_cond();
        address_phase(7'h3B, 1'b0, NACK);
        data_byte(8'h5A, NACK);
        stop_cond();
        start_cond();
        address_phase(7'h1A, 1'b1, NACK);
        collect_byte(NACK, 8'hFF);
        stop_cond();
        if (oe_seen) begin
            $display("DUT pulled SDA low during a transfer to a foreign address");
            err_cnt++;
        end
        oe_watch <= 1'b0;
        repeat (2) xfer_q.push_back(rand_byte());
        write_regs(4'd3);
        read_regs(4'd3, 2);
    endtask

    task automatic abort_test();
        repeat (2) xfer_q.push_back(rand_byte());
        write_regs(4'd9);
        pointer_phase(4'd9);
        partial_bits(~shadow[9]);
        stop_cond();
        read_regs(4'd9, 1);
        pointer_phase(4'd10);
        partial_bits(~shadow[10]);
        restart_cond();
        address_phase(TGT_ADDR, 1'b1, ACK);
        collect_byte(NACK, expected_read(0));
        stop_cond();
    endtask

    task automatic random_test();
        logic [31:0] r;
        int          len;
        repeat (40) begin
            r   = $random(seed);
            len = 1 + int'(r[10:8]) % 6;
            if (r[0]) begin
                read_regs(r[7:4], len);
            end else begin
                repeat (len) xfer_q.push_back(rand_byte());
                write_regs(r[7:4]);
            end
        end
    endtask

    task automatic close_test(input string name);
        wait_drain();
        if (err_cnt == test_err) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d error(s)", name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    initial begin
        i_rst_n   = 1'b0;
        scl_m     = 1'b1;
        sda_pd    = 1'b0;
        oe_watch  = 1'b0;
        seed      = 99532;
        err_cnt   = 0;
        test_err  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        sh_ptr    = '0;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (8) @(posedge i_sysclk);
        i_rst_n <= 1'b1;
        pause(HALF);
        addressing_test();
        close_test("address match and foreign address");
        repeat (4) xfer_q.push_back(rand_byte());
        write_regs(4'd5);
        read_regs(4'd5, 4);
        close_test("write then read back at pointer 5");
        repeat (4) xfer_q.push_back(rand_byte());
        write_regs(4'd14);
        read_regs(4'd0, 16);
        close_test("pointer wrap and full bank read");
        abort_test();
        close_test("stop and restart inside a byte");
        random_test();
        close_test("random transactions");
        $display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/i2c_line_cond.sv
`timescale 1ns/1ps
`include "i2c_slv_defs.svh"

module i2c_line_cond (
    input  logic    i_sysclk,
    input  logic    i_rst_n,
    input  logic    i_scl,
    input  logic    i_sda,
    i2c_line_if.src o_line
);

    logic [`I2C_SYNC_STAGES-1:0] scl_sync;
    logic [`I2C_SYNC_STAGES-1:0] sda_sync;
    logic                        scl_new;
    logic                        sda_new;
    logic                        scl_old;
    logic                        sda_old;

    assign scl_new = scl_sync[`I2C_SYNC_STAGES-1];
    assign sda_new = sda_sync[`I2C_SYNC_STAGES-1];

    // the history flop is also the level seen by the FSM, so a sampled
    // bit lines up with the scl_rise pulse that samples it.
    assign o_line.sda_lvl = sda_old;

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // an idle bus is pulled high.
            scl_sync         <= '1;
            sda_sync         <= '1;
            scl_old          <= 1'b1;
            sda_old          <= 1'b1;
            o_line.scl_rise  <= 1'b0;
            o_line.scl_fall  <= 1'b0;
            o_line.start_det <= 1'b0;
            o_line.stop_det  <= 1'b0;
        end else begin
            scl_sync <= {scl_sync[`I2C_SYNC_STAGES-2:0], i_scl};
            sda_sync <= {sda_sync[`I2C_SYNC_STAGES-2:0], i_sda};
            scl_old  <= scl_new;
            sda_old  <= sda_new;

            o_line.scl_rise  <= ~scl_old & scl_new;
            o_line.scl_fall  <= scl_old & ~scl_new;
            // SDA may only move with SCL high for a start or a stop.
            o_line.start_det <= scl_old & scl_new & sda_old & ~sda_new;
            o_line.stop_det  <= scl_old & scl_new & ~sda_old & sda_new;
        end
    end

endmodule

//--- hw/i2c_line_if.sv
`timescale 1ns/1ps

interface i2c_line_if ();

    // pulses are one i_sysclk cycle wide.
    logic scl_rise;
    logic scl_fall;
    logic sda_lvl;
    logic start_det;
    logic stop_det;

    modport src (
        output scl_rise,
        output scl_fall,
        output sda_lvl,
        output start_det,
        output stop_det
    );

    modport dst (
        input scl_rise,
        input scl_fall,
        input sda_lvl,
        input start_det,
        input stop_det
    );

endinterface

//--- hw/i2c_reg_file.sv
`timescale 1ns/1ps
`include "i2c_slv_defs.svh"

module i2c_reg_file import i2c_slv_pkg::*; (
    input  logic     i_sysclk,
    input  logic     i_rst_n,
    i2c_reg_if.slave i_reg
);

    i2c_byte_t             regs [`I2C_REG_NUM];
    logic [`I2C_PTR_W-1:0] ptr;
    logic [`I2C_PTR_W-1:0] ptr_inc;

    // the pointer width makes the increment wrap at the end of the bank.
    assign ptr_inc = ptr + 1'b1;

    // while rd_next is high the read port already shows the entry the
    // pointer moves to, so the next transmit byte loads on that same edge.
    assign i_reg.rd_data = i_reg.rd_next ? regs[ptr_inc] : regs[ptr];

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ptr <= '0;
            for (int i = 0; i < `I2C_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_reg.ptr_load) begin
                ptr <= i_reg.wr_data[`I2C_PTR_W-1:0];
            end else if (i_reg.wr_en) begin
                regs[ptr] <= i_reg.wr_data;
                ptr       <= ptr_inc;
            end else if (i_reg.rd_next) begin
                ptr <= ptr_inc;
            end
        end
    end

endmodule

//--- hw/i2c_reg_if.sv
`timescale 1ns/1ps

interface i2c_reg_if import i2c_slv_pkg::*; ();

    logic      ptr_load;
    logic      wr_en;
    i2c_byte_t wr_data;
    logic      rd_next;
    i2c_byte_t rd_data;

    modport master (
        output ptr_load,
        output wr_en,
        output wr_data,
        output rd_next,
        input  rd_data
    );

    modport slave (
        input  ptr_load,
        input  wr_en,
        input  wr_data,
        input  rd_next,
        output rd_data
    );

endinterface

//--- hw/i2c_slv_defs.svh
`ifndef I2C_SLV_DEFS_SVH
`define I2C_SLV_DEFS_SVH

// ######################################################################
// target identity and register bank geometry
// ######################################################################

// 7-bit bus address this target answers to.
`define I2C_SLV_ADDR 7'h3A

// number of byte registers and the width of the byte pointer.
`define I2C_REG_NUM 16
`define I2C_PTR_W 4

// ######################################################################
// line conditioning
// ######################################################################

// flops between the pins and the first edge history register.
`define I2C_SYNC_STAGES 2

`endif

//--- hw/i2c_slv_fsm.sv
`timescale 1ns/1ps
`include "i2c_slv_defs.svh"

module i2c_slv_fsm import i2c_slv_pkg::*; (
    input  logic       i_sysclk,
    input  logic       i_rst_n,
    i2c_line_if.dst    i_line,
    i2c_reg_if.master  o_reg,
    output logic       o_sda_oe
);

    i2c_state_e   state;
    logic [2:0]   bit_cnt;
    i2c_rx_byte_u rx_byte;
    i2c_byte_t    tx_byte;
    i2c_ack_e     mst_ack;
    logic         first_byte;
    logic         ptr_set;
    logic         rd_dir;
    logic         byte_done;
    logic         addr_hit;
    logic         tx_load;
    logic         tx_shift;

    // ##################################################################
    // per-cycle decode
    // ##################################################################

    // the eighth falling edge of a received byte.
    assign byte_done = (state == RX_BYTE) && i_line.scl_fall && (bit_cnt == 3'd0);
    assign addr_hit  = (rx_byte.adr.addr == `I2C_SLV_ADDR);

    // only write transfers reach RX_BYTE after the address, so a data byte
    // here is either the pointer or a register write.
    assign o_reg.wr_data  = rx_byte.data;
    assign o_reg.ptr_load = byte_done && !first_byte && !ptr_set;
    assign o_reg.wr_en    = byte_done && !first_byte && ptr_set;
    assign o_reg.rd_next  = (state == RX_ACK) && i_line.scl_fall && (mst_ack == ACK);

    // a new transmit byte starts after the address ack of a read or after
    // an ack from the master.
    assign tx_load  = ((state == TX_ACK) && i_line.scl_fall && rd_dir) || o_reg.rd_next;
    assign tx_shift = (state == TX_BYTE) && i_line.scl_fall && (bit_cnt != 3'd0);

    // ##################################################################
    // shift registers
    // ##################################################################

    always_ff @(posedge i_sysclk) begin
        if ((state == RX_BYTE) && i_line.scl_rise) begin
            rx_byte.data <= {rx_byte.data[6:0], i_line.sda_lvl};
        end
        if (tx_load) begin
            tx_byte <= o_reg.rd_data;
        end else if (tx_shift) begin
            tx_byte <= {tx_byte[6:0], 1'b0};
        end
    end

    // ##################################################################
    // protocol FSM
    // ##################################################################

    always_ff @(posedge i_sysclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= IDLE;
            bit_cnt    <= 3'd7;
            first_byte <= 1'b1;
            ptr_set    <= 1'b0;
            rd_dir     <= 1'b0;
            mst_ack    <= NACK;
            o_sda_oe   <= 1'b0;
        end else if (i_line.stop_det) begin
            state    <= STOP;
            o_sda_oe <= 1'b0;
        end else if (i_line.start_det) begin
            // a start in the middle of a transfer drops the partial byte.
            o_sda_oe <= 1'b0;
            if ((state == IDLE) || (state == STOP)) begin
                state <= START;
            end else begin
                state <= RESTART;
            end
        end else begin
            case (state)
                START, RESTART: begin
                    if (i_line.scl_fall) begin
                        state      <= RX_BYTE;
                        bit_cnt    <= 3'd7;
                        first_byte <= 1'b1;
                        ptr_set    <= 1'b0;
                    end
                end
                RX_BYTE: begin
                    if (i_line.scl_fall) begin
                        if (bit_cnt != 3'd0) begin
                            bit_cnt <= bit_cnt - 3'd1;
                        end else if (first_byte && !addr_hit) begin
                            // not ours, SDA stays released for a NACK.
                            state <= IDLE;
                        end else begin
                            state    <= TX_ACK;
                            o_sda_oe <= 1'b1;
                            if (first_byte) begin
                                first_byte <= 1'b0;
                                rd_dir     <= rx_byte.adr.rw;
                            end else begin
                                ptr_set <= 1'b1;
                            end
                        end
                    end
                end
                TX_ACK: begin
                    if (i_line.scl_fall) begin
                        bit_cnt <= 3'd7;
                        if (rd_dir) begin
                            state    <= TX_BYTE;
                            o_sda_oe <= ~o_reg.rd_data[7];
                        end else begin
                            state    <= RX_BYTE;
                            o_sda_oe <= 1'b0;
                        end
                    end
                end
                TX_BYTE: begin
                    if (i_line.scl_fall) begin
                        if (bit_cnt != 3'd0) begin
                            bit_cnt  <= bit_cnt - 3'd1;
                            o_sda_oe <= ~tx_byte[6];
                        end else begin
                            state    <= RX_ACK;
                            o_sda_oe <= 1'b0;
                        end
                    end
                end
                RX_ACK: begin
                    if (i_line.scl_rise) begin
                        mst_ack <= i2c_ack_e'(i_line.sda_lvl);
                    end
                    if (i_line.scl_fall) begin
                        bit_cnt <= 3'd7;
                        if (mst_ack == ACK) begin
                            state    <= TX_BYTE;
                            o_sda_oe <= ~o_reg.rd_data[7];
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                STOP: begin
                    state <= IDLE;
                end
                default: begin
                    // idle waits for a start condition.
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/i2c_slv_pkg.sv
package i2c_slv_pkg;

    // ##################################################################
    // protocol FSM
    // ##################################################################

    typedef enum logic [3:0] {
        IDLE    = 4'd0,
        START   = 4'd1,
        RX_BYTE = 4'd2,
        TX_ACK  = 4'd3,
        TX_BYTE = 4'd4,
        RX_ACK  = 4'd5,
        RESTART = 4'd6,
        STOP    = 4'd7
    } i2c_state_e;

    // level on SDA during the ninth clock of a byte.
    typedef enum logic {
        ACK  = 1'b0,
        NACK = 1'b1
    } i2c_ack_e;

    typedef logic [7:0] i2c_byte_t;

    // ##################################################################
    // receive shift register
    // ##################################################################

    // the first byte after a start is an address with the direction in
    // the lsb, every later byte is plain data.
    typedef union packed {
        struct packed {
            logic [6:0] addr;
            logic       rw;
        } adr;
        i2c_byte_t data;
    } i2c_rx_byte_u;

endpackage

//--- hw/i2c_slv_top.sv
`timescale 1ns/1ps

module i2c_slv_top (
    input  logic i_sysclk,
    input  logic i_rst_n,
    input  logic i_scl,
    input  logic i_sda,
    output logic o_sda_oe
);

    // ##################################################################
    // internal buses
    // ##################################################################

    i2c_line_if u_line_if ();
    i2c_reg_if  u_reg_if ();

    // ##################################################################
    // pins to bus events
    // ##################################################################

    i2c_line_cond u_line_cond (
        .i_sysclk (i_sysclk),
        .i_rst_n  (i_rst_n),
        .i_scl    (i_scl),
        .i_sda    (i_sda),
        .o_line   (u_line_if)
    );

    // ##################################################################
    // protocol and storage
    // ##################################################################

    // o_sda_oe is a pull-down enable, the pad itself is outside.
    i2c_slv_fsm u_slv_fsm (
        .i_sysclk (i_sysclk),
        .i_rst_n  (i_rst_n),
        .i_line   (u_line_if),
        .o_reg    (u_reg_if),
        .o_sda_oe (o_sda_oe)
    );

    i2c_reg_file u_reg_file (
        .i_sysclk (i_sysclk),
        .i_rst_n  (i_rst_n),
        .i_reg    (u_reg_if)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in sim.log
rm -f sim.log
verilator --binary --timescale 1ns/1ps -f sim.f --top-module i2c_slv_tb -o i2c_slv_sim \
    && ./obj_dir/i2c_slv_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -q "^\*\*\* PASSED \*\*\*$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim.f
+incdir+hw
hw/i2c_slv_pkg.sv
hw/i2c_line_if.sv
hw/i2c_reg_if.sv
hw/i2c_line_cond.sv
hw/i2c_slv_fsm.sv
hw/i2c_reg_file.sv
hw/i2c_slv_top.sv
bench/i2c_slv_tb.sv
